// File: logic/neoIo_defines.svh
`ifndef NEOIO_DEFINES_SVH
`define NEOIO_DEFINES_SVH

// APB byte address width for the I/O window
`define NEO_ADDR_W 6

// Cartridge slots driven by nSlot
`define NEO_SLOTS 6

// Read-only input words
`define REG_P1CNT      6'h00
`define REG_DIPSW      6'h02
`define REG_STATUS_A   6'h04
`define REG_P2CNT      6'h06
`define REG_STATUS_B   6'h08

// Write-only output registers
`define REG_POUTPUT    6'h10
`define REG_SLOT       6'h12
`define REG_LEDLATCHES 6'h14
`define REG_LEDDATA    6'h16
`define REG_COIN       6'h18

// Base of the eight system latch words, 0x20 to 0x2E
`define REG_SYSLATCH   6'h20

`endif

// File: logic/neoBusPkg.sv
`include "neoIo_defines.svh"

package neoBusPkg;

	// Master side of the APB port
	typedef struct packed {
		// Slave select
		logic psel;
		// High in the access phase
		logic penable;
		// 1 for write, 0 for read
		logic pwrite;
		// Even byte offsets only
		logic [`NEO_ADDR_W-1:0] paddr;
		logic [15:0] pwdata;
	} apbReq;

	// Slave side of the APB port
	typedef struct packed {
		logic [15:0] prdata;
		// No wait states in this block
		logic pready;
		// Unmapped offset or wrong direction
		logic pslverr;
	} apbRsp;

endpackage

// File: logic/neoIoPkg.sv
package neoIoPkg;

	// One joypad, all bits active low
	typedef struct packed {
		logic select;
		logic start;
		// A, B, C, D in bits 0 to 3
		logic [3:0] buttons;
		// Up, down, left, right in bits 0 to 3
		logic [3:0] dirs;
	} playerIn;

	// Everything the board presents to the CPU
	typedef struct packed {
		playerIn p2;
		playerIn p1;
		logic [7:0] dipSw;
		logic testBtn;
		// Coin slots and service switch
		logic [3:0] coinSvc;
	} boardIn;

	// Serial LED driver, clock then data
	typedef struct packed {
		logic clk;
		logic [7:0] data;
	} ledPort;

	// EL panel driver
	typedef struct packed {
		logic clk;
		logic [2:0] data;
	} elPort;

	// Bit n matches select code n in a COIN write
	typedef struct packed {
		logic lockout2;
		logic lockout1;
		logic counter2;
		logic counter1;
	} coinOut;

	// Bit n is latch index n
	typedef struct packed {
		logic palBank;
		logic sramUnlock;
		logic system;
		logic regEn;
		logic cardWeB;
		logic cardWe;
		logic vecSwap;
		logic shadow;
	} sysBits;

	// Write enables, valid for the completing access phase only
	typedef struct packed {
		logic sysLatch;
		logic pOutput;
		logic slot;
		logic ledLatches;
		logic ledData;
		logic coin;
		// Latch index from offset bits 3 to 1
		logic [2:0] idx;
		logic [15:0] data;
	} strobes;

endpackage

// File: logic/ioDecode.sv
`include "neoIo_defines.svh"

module ioDecode (
	input logic clk24M,
	input logic arstN,
	input neoBusPkg::apbReq req,
	output neoBusPkg::apbRsp rsp,
	input neoIoPkg::boardIn pins,
	input neoIoPkg::sysBits sys,
	output neoIoPkg::strobes wr
);

	logic access;
	logic wrEn;
	logic [`NEO_ADDR_W-1:0] addr;
	logic isSysLatch;
	logic rdOk;
	logic wrOk;
	logic [15:0] rdData;

	// Access phase of a selected transfer
	assign access = req.psel & req.penable;
	assign wrEn = access & req.pwrite;
	assign addr = req.paddr;

	// Eight latch words share one block, odd offsets excluded
	assign isSysLatch = (addr[5:4] == 2'b10) && !addr[0];

	// Read word table
	always_comb begin
		rdOk = 1'b1;
		rdData = '0;
		if (isSysLatch) begin
			rdData = {8'h00, sys};
		end else begin
			case (addr)
				`REG_P1CNT: rdData = {8'h00, pins.p1.buttons, pins.p1.dirs};
				`REG_P2CNT: rdData = {8'h00, pins.p2.buttons, pins.p2.dirs};
				`REG_DIPSW: rdData = {8'h00, pins.dipSw};
				// Test button on top, coin and service below
				`REG_STATUS_A: rdData = {8'h00, pins.testBtn, 3'b000, pins.coinSvc};
				// Start and select pairs, system mode flag on top
				`REG_STATUS_B: begin
					rdData = {8'h00, sys.system, 3'b000,
						pins.p2.select, pins.p2.start,
						pins.p1.select, pins.p1.start};
				end
				default: rdOk = 1'b0;
			endcase
		end
	end

	// Writable offsets
	always_comb begin
		case (addr)
			`REG_POUTPUT,
			`REG_SLOT,
			`REG_LEDLATCHES,
			`REG_LEDDATA,
			`REG_COIN: wrOk = 1'b1;
			default: wrOk = isSysLatch;
		endcase
	end

	// One strobe per register, only for a legal write
	assign wr.sysLatch = wrEn & isSysLatch;
	assign wr.pOutput = wrEn & (addr == `REG_POUTPUT);
	assign wr.slot = wrEn & (addr == `REG_SLOT);
	assign wr.ledLatches = wrEn & (addr == `REG_LEDLATCHES);
	assign wr.ledData = wrEn & (addr == `REG_LEDDATA);
	assign wr.coin = wrEn & (addr == `REG_COIN);
	assign wr.idx = addr[3:1];
	assign wr.data = req.pwdata;

	// Never stalls
	assign rsp.pready = 1'b1;
	// Data only on a legal read, zero otherwise
	assign rsp.prdata = (access & !req.pwrite & rdOk) ? rdData : 16'h0000;
	assign rsp.pslverr = access & (req.pwrite ? !wrOk : !rdOk);

	// Write table and strobe decode must agree, an error write touches nothing
	aErrNoStrobe: assert property (@(posedge clk24M) disable iff (!arstN)
		rsp.pslverr |-> !(wr.sysLatch | wr.pOutput | wr.slot |
			wr.ledLatches | wr.ledData | wr.coin));

	// Register blocks never see two writes at once
	aOneStrobe: assert property (@(posedge clk24M) disable iff (!arstN)
		$onehot0({wr.sysLatch, wr.pOutput, wr.slot, wr.ledLatches, wr.ledData, wr.coin}));

endmodule

// File: logic/sysLatch.sv
module sysLatch (
	input logic clk24M,
	input logic arstN,
	input neoIoPkg::strobes wr,
	output neoIoPkg::sysBits sys
);

	logic [7:0] bits;

	// Addressable latch
	// Index picks the bit, data bit 0 is the new level
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			bits <= '0;
		end else if (wr.sysLatch) begin
			bits[wr.idx] <= wr.data[0];
		end
	end

	// Bit order matches the struct field order
	assign sys = bits;

	// Decoder must hand over a clean index with every strobe
	aIdxKnown: assert property (@(posedge clk24M) disable iff (!arstN)
		wr.sysLatch |-> !$isunknown(wr.idx));

endmodule

// File: logic/slotLedPort.sv
`include "neoIo_defines.svh"

module slotLedPort (
	input logic clk24M,
	input logic arstN,
	input neoIoPkg::strobes wr,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [`NEO_SLOTS-1:0] nSlot,
	output neoIoPkg::ledPort ledOut1,
	output neoIoPkg::ledPort ledOut2,
	output neoIoPkg::elPort elOut
);

	logic [2:0] slotSel;
	logic [7:0] ledHold;
	logic [2:0] latchPrev;
	logic [2:0] rise;

	// Joypad output pins
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			p1Out <= '0;
			p2Out <= '0;
		end else if (wr.pOutput) begin
			p1Out <= wr.data[2:0];
			p2Out <= wr.data[5:3];
		end
	end

	// Slot number, 0 after reset
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			slotSel <= '0;
		end else if (wr.slot) begin
			slotSel <= wr.data[2:0];
		end
	end

	// Active low one-hot select, codes past the last slot select none
	always_comb begin
		for (int i = 0; i < `NEO_SLOTS; i++) begin
			nSlot[i] = (slotSel != 3'(i));
		end
	end

	// Pending LED data, only shifted out on a latch edge
	always_ff @(posedge clk24M) begin
		if (wr.ledData) begin
			ledHold <= wr.data[7:0];
		end
	end

	// Latch bits 3, 4 and 5 load LED1, LED2 and EL on a 0 to 1 edge
	assign rise = wr.ledLatches ? (wr.data[5:3] & ~latchPrev) : 3'b000;

	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			latchPrev <= '0;
			ledOut1 <= '0;
			ledOut2 <= '0;
			elOut <= '0;
		end else begin
			if (wr.ledLatches) begin
				latchPrev <= wr.data[5:3];
			end
			// Clocks idle low, high for the cycle after a load
			ledOut1.clk <= rise[0];
			ledOut2.clk <= rise[1];
			elOut.clk <= rise[2];
			if (rise[0]) begin
				ledOut1.data <= ledHold;
			end
			if (rise[1]) begin
				ledOut2.data <= ledHold;
			end
			// EL panel only takes the low three bits
			if (rise[2]) begin
				elOut.data <= ledHold[2:0];
			end
		end
	end

	// Slot code must be clean whenever it is written
	aSlotKnown: assert property (@(posedge clk24M) disable iff (!arstN)
		wr.slot |-> !$isunknown(wr.data[2:0]));

	// Load clocks are single-cycle pulses
	aLed1Pulse: assert property (@(posedge clk24M) disable iff (!arstN)
		ledOut1.clk |=> !ledOut1.clk);
	aLed2Pulse: assert property (@(posedge clk24M) disable iff (!arstN)
		ledOut2.clk |=> !ledOut2.clk);
	aElPulse: assert property (@(posedge clk24M) disable iff (!arstN)
		elOut.clk |=> !elOut.clk);

endmodule

// File: logic/coinControl.sv
module coinControl (
	input logic clk24M,
	input logic arstN,
	input neoIoPkg::strobes wr,
	output neoIoPkg::coinOut coins
);

	logic [3:0] outBits;

	// Data bits 1 to 0 pick the output
	// 0 counter1, 1 counter2, 2 lockout1, 3 lockout2
	// Data bit 2 sets or clears it
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			outBits <= '0;
		end else if (wr.coin) begin
			outBits[wr.data[1:0]] <= wr.data[2];
		end
	end

	assign coins = outBits;

	// Select and level must be clean on every COIN write
	aCoinDataKnown: assert property (@(posedge clk24M) disable iff (!arstN)
		wr.coin |-> !$isunknown(wr.data[2:0]));

endmodule

// File: logic/neoIoTop.sv
`include "neoIo_defines.svh"

module neoIoTop (
	input logic clk24M,
	input logic arstN,
	input neoBusPkg::apbReq req,
	output neoBusPkg::apbRsp rsp,
	input neoIoPkg::boardIn pins,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [`NEO_SLOTS-1:0] nSlot,
	output neoIoPkg::ledPort ledOut1,
	output neoIoPkg::ledPort ledOut2,
	output neoIoPkg::elPort elOut,
	output neoIoPkg::coinOut coins,
	output neoIoPkg::sysBits sys
);

	import neoIoPkg::*;

	// Decoder to register blocks
	strobes wr;

	// Bus control, also reads back the system latch
	ioDecode uDecode (
		.clk24M(clk24M),
		.arstN(arstN),
		.req(req),
		.rsp(rsp),
		.pins(pins),
		.sys(sys),
		.wr(wr)
	);

	sysLatch uSysLatch (
		.clk24M(clk24M),
		.arstN(arstN),
		.wr(wr),
		.sys(sys)
	);

	// Slot, joypad and LED side
	slotLedPort uSlotLed (
		.clk24M(clk24M),
		.arstN(arstN),
		.wr(wr),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.nSlot(nSlot),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2),
		.elOut(elOut)
	);

	coinControl uCoin (
		.clk24M(clk24M),
		.arstN(arstN),
		.wr(wr),
		.coins(coins)
	);

endmodule

// File: sim/tbNeoIoTasks.svh
`ifndef TBNEOIOTASKS_SVH
`define TBNEOIOTASKS_SVH

function automatic logic [31:0] nextRandom();
	return $random(seed);
endfunction

task automatic reportFailure(input string what);
	$display("FAIL at %0t: %s", $time, what);
	otherErrs++;
endtask

task automatic logMismatch(input string name, input logic [15:0] exp, input logic [15:0] act);
	$display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
	valueErrs++;
endtask

task automatic checkWord(input string name, input logic [15:0] exp, input logic [15:0] act);
	if (act !== exp) begin
		logMismatch(name, exp, act);
	end
endtask

task automatic checkSys(input string name, input sysBits exp, input sysBits act);
	if (act !== exp) begin
		logMismatch(name, {8'h00, exp}, {8'h00, act});
	end
endtask

task automatic checkCoins(input string name, input coinOut exp, input coinOut act);
	if (act !== exp) begin
		logMismatch(name, {12'h000, exp}, {12'h000, act});
	end
endtask

task automatic checkLed(input string name, input ledPort exp, input ledPort act);
	if (act !== exp) begin
		logMismatch(name, {7'h00, exp}, {7'h00, act});
	end
endtask

task automatic checkEl(input string name, input elPort exp, input elPort act);
	if (act !== exp) begin
		logMismatch(name, {12'h000, exp}, {12'h000, act});
	end
endtask

task automatic checkSlot(input string name, input logic [5:0] exp, input logic [5:0] act);
	if (act !== exp) begin
		logMismatch(name, {10'h000, exp}, {10'h000, act});
	end
endtask

// Setup cycle, access cycle, then idle
// A write lands on the edge that ends the access phase
task automatic apbTransfer(input logic [`NEO_ADDR_W-1:0] addr, input logic write,
		input logic [15:0] wdata, input logic expErr, output logic [15:0] rdata);
	logic err;
	@(posedge clk24M);
	#1;
	req.psel = 1'b1;
	req.penable = 1'b0;
	req.pwrite = write;
	req.paddr = addr;
	req.pwdata = wdata;
	@(posedge clk24M);
	#1;
	req.penable = 1'b1;
	// Mid access phase, no edge nearby
	#1;
	rdata = rsp.prdata;
	err = rsp.pslverr;
	if (rsp.pready !== 1'b1) begin
		reportFailure($sformatf("pready low in access phase at offset %h", addr));
	end
	@(posedge clk24M);
	#1;
	req.psel = 1'b0;
	req.penable = 1'b0;
	req.pwrite = 1'b0;
	if (err !== expErr) begin
		reportFailure($sformatf("pslverr was %b for offset %h, write %b", err, addr, write));
	end
endtask

task automatic apbWrite(input logic [`NEO_ADDR_W-1:0] addr, input logic [15:0] data,
		input logic expErr);
	logic [15:0] unused;
	apbTransfer(addr, 1'b1, data, expErr, unused);
endtask

task automatic apbRead(input logic [`NEO_ADDR_W-1:0] addr, output logic [15:0] data,
		input logic expErr);
	apbTransfer(addr, 1'b0, 16'h0000, expErr, data);
endtask

function automatic logic [45:0] outputSnapshot();
	return {sys, coins, ledOut1, ledOut2, elOut, nSlot, p1Out, p2Out};
endfunction

task automatic resetValues();
	checkLed("ledOut1", 9'h000, ledOut1);
	checkLed("ledOut2", 9'h000, ledOut2);
	checkEl("elOut", 4'h0, elOut);
	checkCoins("coins", 4'h0, coins);
	checkSys("sys", 8'h00, sys);
	checkWord("p1Out", 16'h0000, {13'h0000, p1Out});
	checkWord("p2Out", 16'h0000, {13'h0000, p2Out});
	// Slot 0 selected
	checkSlot("nSlot", 6'b111110, nSlot);
	if (rsp.pslverr !== 1'b0) begin
		reportFailure("pslverr high on an idle bus after reset");
	end
endtask

task automatic inputReads();
	logic [31:0] r;
	logic [31:0] t;
	logic [15:0] d;
	for (int n = 0; n < 3; n++) begin
		r = nextRandom();
		t = nextRandom();
		@(posedge clk24M);
		#1;
		pins.p1 = r[9:0];
		pins.p2 = r[19:10];
		pins.dipSw = r[27:20];
		pins.coinSvc = r[31:28];
		pins.testBtn = t[0];
		// Buttons and directions are the low byte of each joypad field
		apbRead(`REG_P1CNT, d, 1'b0);
		checkWord("P1CNT", {8'h00, r[7:0]}, d);
		apbRead(`REG_P2CNT, d, 1'b0);
		checkWord("P2CNT", {8'h00, r[17:10]}, d);
		apbRead(`REG_DIPSW, d, 1'b0);
		checkWord("DIPSW", {8'h00, r[27:20]}, d);
		apbRead(`REG_STATUS_A, d, 1'b0);
		checkWord("STATUS_A", {8'h00, t[0], 3'b000, r[31:28]}, d);
		// System bit is latch index 5
		// Select above start and player 2 above player 1
		apbRead(`REG_STATUS_B, d, 1'b0);
		checkWord("STATUS_B", {8'h00, sysModel[5], 3'b000, r[19], r[18], r[9], r[8]}, d);
	end
endtask

task automatic sysLatchWrites();
	logic [31:0] r;
	logic [15:0] d;
	logic [2:0] idx;
	for (int n = 0; n < 16; n++) begin
		r = nextRandom();
		// Walk all indexes first, then pick them at random
		idx = (n < 8) ? 3'(n) : r[3:1];
		sysModel[idx] = r[0];
		apbWrite(`REG_SYSLATCH | {2'b00, idx, 1'b0}, {15'h0000, r[0]}, 1'b0);
		checkSys("sys", sysModel, sys);
		apbRead(`REG_SYSLATCH | {2'b00, idx, 1'b0}, d, 1'b0);
		checkWord("SYSLATCH", {8'h00, sysModel}, d);
	end
	apbRead(`REG_STATUS_B, d, 1'b0);
	checkWord("STATUS_B bit 7", {8'h00, sysModel[5], 7'h00}, d & 16'h0080);
endtask

task automatic slotJoypad();
	logic [31:0] r;
	logic [5:0] exp;
	for (int n = 0; n < 8; n++) begin
		apbWrite(`REG_SLOT, 16'(n), 1'b0);
		// Codes 6 and 7 leave every slot off
		exp = (n < `NEO_SLOTS) ? ~(6'b000001 << n) : 6'h3F;
		checkSlot("nSlot", exp, nSlot);
	end
	for (int n = 0; n < 4; n++) begin
		r = nextRandom();
		apbWrite(`REG_POUTPUT, {10'h000, r[5:0]}, 1'b0);
		checkWord("p1Out", {13'h0000, r[2:0]}, {13'h0000, p1Out});
		checkWord("p2Out", {13'h0000, r[5:3]}, {13'h0000, p2Out});
	end
endtask

task automatic ledElCoins();
	logic [31:0] r;
	logic [7:0] d1;
	logic [7:0] d2;
	logic [7:0] d3;
	logic [1:0] sel;
	logic lvl;
	r = nextRandom();
	d1 = r[7:0];
	d2 = r[15:8];
	d3 = r[23:16];
	// Bit 3 rises, LED1 loads and pulses
	apbWrite(`REG_LEDDATA, {8'h00, d1}, 1'b0);
	apbWrite(`REG_LEDLATCHES, 16'h0008, 1'b0);
	checkLed("ledOut1", {1'b1, d1}, ledOut1);
	checkLed("ledOut2", 9'h000, ledOut2);
	@(posedge clk24M);
	#1;
	checkLed("ledOut1", {1'b0, d1}, ledOut1);
	// Bit 3 already high, only LED2 loads
	apbWrite(`REG_LEDDATA, {8'h00, d2}, 1'b0);
	apbWrite(`REG_LEDLATCHES, 16'h0018, 1'b0);
	checkLed("ledOut1", {1'b0, d1}, ledOut1);
	checkLed("ledOut2", {1'b1, d2}, ledOut2);
	// EL takes the low three data bits
	apbWrite(`REG_LEDDATA, {8'h00, d3}, 1'b0);
	apbWrite(`REG_LEDLATCHES, 16'h0038, 1'b0);
	checkLed("ledOut1", {1'b0, d1}, ledOut1);
	checkLed("ledOut2", {1'b0, d2}, ledOut2);
	checkEl("elOut", {1'b1, d3[2:0]}, elOut);
	@(posedge clk24M);
	#1;
	checkEl("elOut", {1'b0, d3[2:0]}, elOut);
	// Falling bits load nothing, a new rise reloads LED1
	apbWrite(`REG_LEDLATCHES, 16'h0000, 1'b0);
	checkLed("ledOut1", {1'b0, d1}, ledOut1);
	apbWrite(`REG_LEDLATCHES, 16'h0008, 1'b0);
	checkLed("ledOut1", {1'b1, d3}, ledOut1);
	// Set all four coin outputs, then clear them in another order
	for (int n = 0; n < 8; n++) begin
		sel = (n < 4) ? 2'(n) : 2'(n * 3);
		lvl = (n < 4);
		coinModel[sel] = lvl;
		apbWrite(`REG_COIN, {13'h0000, lvl, sel}, 1'b0);
		checkCoins("coins", coinModel, coins);
	end
endtask

task automatic errorAccesses();
	logic [45:0] prior;
	logic [15:0] d;
	prior = outputSnapshot();
	apbWrite(6'h1A, 16'hFFFF, 1'b1);
	apbRead(6'h0C, d, 1'b1);
	apbWrite(`REG_P1CNT, 16'hFFFF, 1'b1);
	// Odd offset inside the latch window
	apbWrite(6'h2B, 16'hFFFF, 1'b1);
	apbRead(`REG_COIN, d, 1'b1);
	@(posedge clk24M);
	#1;
	if (outputSnapshot() !== prior) begin
		reportFailure("board outputs changed after illegal accesses");
	end
endtask

`endif

// File: sim/tbNeoIo.sv
`include "neoIo_defines.svh"

module tbNeoIo;

	import neoBusPkg::*;
	import neoIoPkg::*;

	// Tests take roughly 400 cycles
	localparam int maxCycles = 2000;

	logic clk24M;
	logic arstN;
	apbReq req;
	apbRsp rsp;
	boardIn pins;
	logic [2:0] p1Out;
	logic [2:0] p2Out;
	logic [`NEO_SLOTS-1:0] nSlot;
	ledPort ledOut1;
	ledPort ledOut2;
	elPort elOut;
	coinOut coins;
	sysBits sys;

	integer seed;
	int cycles = 0;
	int valueErrs = 0;
	int otherErrs = 0;

	// Expected contents of the latch and coin flops
	logic [7:0] sysModel;
	logic [3:0] coinModel;

	neoIoTop dut (
		.clk24M(clk24M),
		.arstN(arstN),
		.req(req),
		.rsp(rsp),
		.pins(pins),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.nSlot(nSlot),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2),
		.elOut(elOut),
		.coins(coins),
		.sys(sys)
	);

	`include "tbNeoIoTasks.svh"

	// Board clock, period 4
	initial begin
		clk24M = 1'b0;
		forever begin
			#2;
			clk24M = ~clk24M;
		end
	end

	// Stop a stuck run
	always @(posedge clk24M) begin
		cycles++;
		if (cycles >= maxCycles) begin
			$display("Run stopped after %0d cycles, the test sequence did not finish", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		seed = 32'h9f128fb3;
		sysModel = 8'h00;
		coinModel = 4'h0;
		arstN = 1'b0;
		req = '0;
		// Active low inputs idle high
		pins = '1;
		repeat (16) @(posedge clk24M);
		#1;
		arstN = 1'b1;

		resetValues();
		inputReads();
		sysLatchWrites();
		slotJoypad();
		ledElCoins();
		errorAccesses();

		$display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
		if (valueErrs + otherErrs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+logic
+incdir+sim
logic/neoBusPkg.sv
logic/neoIoPkg.sv
logic/ioDecode.sv
logic/sysLatch.sv
logic/slotLedPort.sv
logic/coinControl.sv
logic/neoIoTop.sv
sim/tbNeoIo.sv

// File: Makefile
TOP := tbNeoIo

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

obj_dir/V$(TOP): tb.f $(wildcard logic/*.sv logic/*.svh sim/*.sv sim/*.svh)
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
